/* rtl/pcgu_pkg.sv */
package pcgu_pkg;

    // ----------------------------------------
    // Clock request sequencer
    // ----------------------------------------

    // Width of the wake and gate hysteresis timer
    parameter int TMR_W = 4;

    // Sequencer states
    typedef enum logic [2:0] {
        // Clock may be gated, any wake source accepted
        SELWAKE   = 3'h0,
        // Clock acked, waiting out wake hysteresis
        NOSEL     = 3'h1,
        // Clock valid for all consumers
        UNGATECLK = 3'h2,
        // Gate requested, waiting out gate hysteresis
        GATEPEND  = 3'h3,
        // Request dropped, waiting for ack to fall
        GATECLK   = 3'h4,
        // Clock may be gated, only the power manager wake accepted
        PMCWAKE   = 3'h5
    } clkreq_state_t;

endpackage

/* rtl/pcgu_wake_if.sv */
`timescale 1ns/10ps

interface pcgu_wake_if;

    // Mask levels from the sequencer
    logic mask_acc_wake;
    logic mask_pmc_wake;

    // Clear controls from the sequencer
    logic clr_acc_wake;
    logic clr_clkreq_sustain;
    logic clr_defon_flag;

    // Status back from wake control
    logic clkreq_sustain;
    logic defon_flag;

    // Sequencer side
    modport seq (
        output mask_acc_wake,
        output mask_pmc_wake,
        output clr_acc_wake,
        output clr_clkreq_sustain,
        output clr_defon_flag,
        input  clkreq_sustain,
        input  defon_flag
    );

    // Wake control side
    modport wake (
        input  mask_acc_wake,
        input  mask_pmc_wake,
        input  clr_acc_wake,
        input  clr_clkreq_sustain,
        input  clr_defon_flag,
        output clkreq_sustain,
        output defon_flag
    );

endinterface

/* rtl/pgcb_doublesync.sv */
`timescale 1ns/10ps

module pgcb_doublesync #(
    parameter int SYNC_STAGES = 2
) (
    input  logic pgcb_clk,
    input  logic pgcb_rst_b,
    input  logic d,
    output logic q
);

    // Synchronizer chain, bit 0 takes the async input
    logic [SYNC_STAGES-1:0] sync_q;

    always_ff @(posedge pgcb_clk, negedge pgcb_rst_b) begin
        if (!pgcb_rst_b) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[SYNC_STAGES-2:0], d};
        end
    end

    // Last stage is safe to use in the pgcb_clk domain
    assign q = sync_q[SYNC_STAGES-1];

endmodule

/* rtl/pcgu_wake_ctrl.sv */
`timescale 1ns/10ps

module pcgu_wake_ctrl #(
    parameter int DEF_PWRON   = 0,
    parameter int SYNC_STAGES = 2
) (
    input  logic        pgcb_clk,
    input  logic        pgcb_rst_b,
    input  logic        async_wake_b,
    input  logic        async_pmc_ip_wake,
    pcgu_wake_if.wake   wake,
    output logic        pgcb_clkreq
);

    logic acc_set_b;
    logic acc_wake_flop;
    logic acc_wake_assert;
    logic defon_flag;
    logic pmc_wake_or_flag;
    logic pmc_wake_assert;
    logic acc_wake_sync;
    logic pmc_wake_sync;
    logic sustain_q;

    // ----------------------------------------
    // Accessible wake capture
    // ----------------------------------------

    // Masked wake, held high while the sequencer ignores it
    assign acc_set_b = async_wake_b | wake.mask_acc_wake;

    // Set asynchronously by the wake
    // Cleared synchronously once the clock runs
    always_ff @(posedge pgcb_clk, negedge pgcb_rst_b, negedge acc_set_b) begin
        if (!pgcb_rst_b) begin
            acc_wake_flop <= 1'b0;
        end else if (!acc_set_b) begin
            acc_wake_flop <= 1'b1;
        end else begin
            acc_wake_flop <= acc_wake_flop & ~wake.clr_acc_wake;
        end
    end

    // Masked off once the sustain flop has taken over
    assign acc_wake_assert = acc_wake_flop & ~wake.mask_acc_wake;

    // ----------------------------------------
    // Power manager wake
    // ----------------------------------------

    // Default-on flag keeps the request up through reset
    if (DEF_PWRON != 0) begin : g_defon
        always_ff @(posedge pgcb_clk, negedge pgcb_rst_b) begin
            if (!pgcb_rst_b) begin
                defon_flag <= 1'b1;
            end else begin
                defon_flag <= defon_flag & ~wake.clr_defon_flag;
            end
        end
    end else begin : g_no_defon
        // Only the power manager can wake
        assign defon_flag = 1'b0;
    end

    assign pmc_wake_or_flag = async_pmc_ip_wake | defon_flag;
    assign pmc_wake_assert  = pmc_wake_or_flag & ~wake.mask_pmc_wake;

    // ----------------------------------------
    // Sustain flop
    // ----------------------------------------

    pgcb_doublesync #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_sync_acc_wake (
        .pgcb_clk   (pgcb_clk),
        .pgcb_rst_b (pgcb_rst_b),
        .d          (acc_wake_assert),
        .q          (acc_wake_sync)
    );

    pgcb_doublesync #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_sync_pmc_wake (
        .pgcb_clk   (pgcb_clk),
        .pgcb_rst_b (pgcb_rst_b),
        .d          (pmc_wake_assert),
        .q          (pmc_wake_sync)
    );

    // Holds the request until the sequencer gates the clock
    always_ff @(posedge pgcb_clk, negedge pgcb_rst_b) begin
        if (!pgcb_rst_b) begin
            sustain_q <= 1'b0;
        end else begin
            sustain_q <= (sustain_q | acc_wake_sync | pmc_wake_sync) & ~wake.clr_clkreq_sustain;
        end
    end

    assign wake.clkreq_sustain = sustain_q;
    assign wake.defon_flag     = defon_flag;

    // Rises combinationally, falls only through the sustain flop
    assign pgcb_clkreq = acc_wake_assert | pmc_wake_assert | sustain_q;

endmodule

/* rtl/pcgu_seq.sv */
`timescale 1ns/10ps

module pcgu_seq #(
    parameter int DEF_PWRON = 0
) (
    input  logic                       pgcb_clk,
    input  logic                       pgcb_rst_b,
    input  logic                       clkack_syn,
    input  logic                       sync_gate,
    input  logic                       pgcb_pok,
    input  logic [pcgu_pkg::TMR_W-1:0] t_clkwake,
    input  logic [pcgu_pkg::TMR_W-1:0] t_clkgate,
    pcgu_wake_if.seq                   seq,
    output logic                       sync_clkvld
);

    pcgu_pkg::clkreq_state_t state_q;
    pcgu_pkg::clkreq_state_t state_d;

    logic [pcgu_pkg::TMR_W-1:0] tmr_q;
    logic [pcgu_pkg::TMR_W-1:0] tmr_d;
    logic                       tmr_expired;
    logic                       reload_wake;
    logic                       reload_gate;
    logic                       tmr_dec;
    logic                       mask_acc_q;
    logic                       mask_pmc_q;

    // ----------------------------------------
    // State machine
    // ----------------------------------------

    always_ff @(posedge pgcb_clk, negedge pgcb_rst_b) begin
        if (!pgcb_rst_b) begin
            state_q <= pcgu_pkg::PMCWAKE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            // Clock acked and request held
            pcgu_pkg::PMCWAKE,
            pcgu_pkg::SELWAKE: begin
                if (clkack_syn && seq.clkreq_sustain) begin
                    state_d = pcgu_pkg::NOSEL;
                end
            end
            // Wake hysteresis done
            pcgu_pkg::NOSEL: begin
                if (tmr_expired) begin
                    state_d = pcgu_pkg::UNGATECLK;
                end
            end
            pcgu_pkg::UNGATECLK: begin
                if (sync_gate) begin
                    state_d = pcgu_pkg::GATEPEND;
                end
            end
            // Gate withdrawn or hysteresis done
            pcgu_pkg::GATEPEND: begin
                if (!sync_gate) begin
                    state_d = pcgu_pkg::UNGATECLK;
                end else if (tmr_expired) begin
                    state_d = pcgu_pkg::GATECLK;
                end
            end
            // Once ack is gone pok picks which wakes count
            pcgu_pkg::GATECLK: begin
                if (!clkack_syn) begin
                    state_d = pgcb_pok ? pcgu_pkg::SELWAKE : pcgu_pkg::PMCWAKE;
                end
            end
            default: begin
                state_d = pcgu_pkg::PMCWAKE;
            end
        endcase
    end

    // Strobes on the transition itself
    assign seq.clr_clkreq_sustain = (state_q == pcgu_pkg::GATEPEND) &&
                                    (state_d == pcgu_pkg::GATECLK);
    assign seq.clr_defon_flag     = (state_q == pcgu_pkg::NOSEL) &&
                                    (state_d == pcgu_pkg::UNGATECLK);
    // Level while the clock is valid
    assign seq.clr_acc_wake       = (state_q == pcgu_pkg::UNGATECLK);

    // ----------------------------------------
    // Hysteresis timer
    // ----------------------------------------

    assign reload_wake = ((state_q == pcgu_pkg::PMCWAKE) || (state_q == pcgu_pkg::SELWAKE)) &&
                         (state_d == pcgu_pkg::NOSEL);
    assign reload_gate = (state_q == pcgu_pkg::UNGATECLK) && (state_d == pcgu_pkg::GATEPEND);
    assign tmr_dec     = (state_q == pcgu_pkg::NOSEL) || (state_q == pcgu_pkg::GATEPEND);

    // Reloads never overlap
    // Decrement only in the two wait states
    always_comb begin
        if (reload_wake) begin
            tmr_d = t_clkwake;
        end else if (reload_gate) begin
            tmr_d = t_clkgate;
        end else if (tmr_dec) begin
            tmr_d = tmr_q - {{(pcgu_pkg::TMR_W-1){1'b0}}, 1'b1};
        end else begin
            tmr_d = tmr_q;
        end
    end

    always_ff @(posedge pgcb_clk, negedge pgcb_rst_b) begin
        if (!pgcb_rst_b) begin
            tmr_q <= '1;
        end else begin
            tmr_q <= tmr_d;
        end
    end

    assign tmr_expired = (tmr_q == '0);

    // ----------------------------------------
    // Registered outputs
    // ----------------------------------------

    always_ff @(posedge pgcb_clk, negedge pgcb_rst_b) begin
        if (!pgcb_rst_b) begin
            mask_pmc_q  <= 1'b0;
            mask_acc_q  <= 1'b1;
            sync_clkvld <= (DEF_PWRON != 0);
        end else begin
            mask_pmc_q  <= (state_d != pcgu_pkg::PMCWAKE) && (state_d != pcgu_pkg::SELWAKE);
            mask_acc_q  <= (state_d != pcgu_pkg::SELWAKE);
            // Default-on flag keeps the clock valid until first ungate
            sync_clkvld <= (state_d == pcgu_pkg::UNGATECLK) || seq.defon_flag;
        end
    end

    assign seq.mask_pmc_wake = mask_pmc_q;
    assign seq.mask_acc_wake = mask_acc_q;

endmodule

/* rtl/pcgu.sv */
`timescale 1ns/10ps

module pcgu #(
    parameter int DEF_PWRON   = 0,
    parameter int SYNC_STAGES = 2
) (
    // Clock, reset and SoC clock handshake
    input  logic                       pgcb_clk,
    input  logic                       pgcb_rst_b,
    output logic                       pgcb_clkreq,
    input  logic                       pgcb_clkack,

    // Hysteresis delays
    input  logic [pcgu_pkg::TMR_W-1:0] t_clkgate,
    input  logic [pcgu_pkg::TMR_W-1:0] t_clkwake,

    // Gate and wake from the clock consumer
    input  logic                       sync_gate,
    input  logic                       async_wake_b,
    output logic                       sync_clkvld,

    // Power gating controller side
    input  logic                       pgcb_pok,
    input  logic                       async_pmc_ip_wake
);

    logic clkack_syn;

    // Controls and status between sequencer and wake logic
    pcgu_wake_if wake_bus ();

    // ----------------------------------------
    // Clock ack synchronizer
    // ----------------------------------------

    pgcb_doublesync #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_sync_clkack (
        .pgcb_clk   (pgcb_clk),
        .pgcb_rst_b (pgcb_rst_b),
        .d          (pgcb_clkack),
        .q          (clkack_syn)
    );

    // ----------------------------------------
    // Wake capture and request
    // ----------------------------------------

    pcgu_wake_ctrl #(
        .DEF_PWRON   (DEF_PWRON),
        .SYNC_STAGES (SYNC_STAGES)
    ) u_wake_ctrl (
        .pgcb_clk          (pgcb_clk),
        .pgcb_rst_b        (pgcb_rst_b),
        .async_wake_b      (async_wake_b),
        .async_pmc_ip_wake (async_pmc_ip_wake),
        .wake              (wake_bus.wake),
        .pgcb_clkreq       (pgcb_clkreq)
    );

    // ----------------------------------------
    // Request sequencer
    // ----------------------------------------

    pcgu_seq #(
        .DEF_PWRON (DEF_PWRON)
    ) u_seq (
        .pgcb_clk    (pgcb_clk),
        .pgcb_rst_b  (pgcb_rst_b),
        .clkack_syn  (clkack_syn),
        .sync_gate   (sync_gate),
        .pgcb_pok    (pgcb_pok),
        .t_clkwake   (t_clkwake),
        .t_clkgate   (t_clkgate),
        .seq         (wake_bus.seq),
        .sync_clkvld (sync_clkvld)
    );

endmodule

/* test/pcgu_checker.sv */
`timescale 1ns/10ps

module pcgu_checker #(
    parameter int SYNC_STAGES = 2,
    parameter int EVENT_LIMIT = 64
) (
    input  logic                       pgcb_clk,
    input  logic                       pgcb_rst_b,
    input  logic                       pgcb_clkreq,
    input  logic                       pgcb_clkack,
    input  logic                       sync_gate,
    input  logic                       async_wake_b,
    input  logic                       async_pmc_ip_wake,
    input  logic                       sync_clkvld,
    // Current table row
    input  logic                       row_busy,
    input  logic                       row_pok,
    input  logic                       row_acc,
    input  logic [pcgu_pkg::TMR_W-1:0] row_t_clkwake,
    input  logic [pcgu_pkg::TMR_W-1:0] row_t_clkgate,
    input  logic                       row_cancel,
    input  logic                       row_wake_exp,
    input  logic                       tests_done,
    output int                         err_total,
    output logic                       report_done
);

    // Conditions the checker can wait for
    localparam int EV_WAKE = 0;
    localparam int EV_ACK  = 1;
    localparam int EV_VLD  = 2;
    localparam int EV_GATE = 3;

    int cur_test;
    int row_errs;
    int n_pass;
    int n_fail;

    function automatic logic cond_now(input int sel);
        case (sel)
            EV_WAKE: return row_acc ? !async_wake_b : async_pmc_ip_wake;
            EV_ACK:  return pgcb_clkack;
            EV_VLD:  return sync_clkvld;
            EV_GATE: return sync_gate;
            default: return 1'b0;
        endcase
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp_val);
        if (got !== exp_val) begin
            $display("FAILED test %0d: %s = 0x%0h, expected 0x%0h", cur_test, name, got, exp_val);
            row_errs++;
        end
    endtask

    // Steps one negedge at a time, gives up after EVENT_LIMIT cycles
    task automatic await_cond(input int sel, input string what, output int cycles,
                              output logic found);
        cycles = 0;
        found  = 1'b0;
        while (!found && cycles < EVENT_LIMIT) begin
            @(negedge pgcb_clk);
            cycles++;
            found = cond_now(sel);
        end
        if (!found) begin
            $display("test %0d: %s", cur_test, what);
            row_errs++;
        end
    endtask

    // ----------------------------------------
    // Gate and gate cancel
    // ----------------------------------------

    task automatic check_gating();
        int   k;
        int   cycles;
        logic found;
        await_cond(EV_GATE, "sync_gate was never raised", cycles, found);
        if (!found) return;
        if (row_cancel) begin
            // Request must survive the whole cancelled gate
            k = 0;
            while (sync_gate && k < EVENT_LIMIT) begin
                @(negedge pgcb_clk);
                k++;
                check_bit("pgcb_clkreq", pgcb_clkreq, 1'b1);
                check_bit("sync_clkvld", sync_clkvld, 1'b0);
            end
            // Clock valid again one edge after the drop
            @(negedge pgcb_clk);
            check_bit("sync_clkvld", sync_clkvld, 1'b1);
            check_bit("pgcb_clkreq", pgcb_clkreq, 1'b1);
            await_cond(EV_GATE, "sync_gate not raised again after the cancel", cycles, found);
            if (!found) return;
        end
        // Valid drops after one edge, request after t_clkgate+2 edges
        for (k = 1; k <= int'(row_t_clkgate) + 2; k++) begin
            @(negedge pgcb_clk);
            check_bit("sync_clkvld", sync_clkvld, 1'b0);
            check_bit("pgcb_clkreq", pgcb_clkreq, k < int'(row_t_clkgate) + 2);
        end
    endtask

    // ----------------------------------------
    // Row kinds
    // ----------------------------------------

    task automatic check_wake_row();
        int   cycles;
        logic found;
        await_cond(EV_WAKE, "wake input was never asserted", cycles, found);
        if (!found) return;
        // Combinational request, same cycle as the wake
        check_bit("pgcb_clkreq", pgcb_clkreq, 1'b1);
        await_cond(EV_ACK, "pgcb_clkack never rose", cycles, found);
        if (!found) return;
        await_cond(EV_VLD, "sync_clkvld never rose", cycles, found);
        if (!found) return;
        if (cycles < int'(row_t_clkwake) + 2 ||
            cycles > SYNC_STAGES + int'(row_t_clkwake) + 4) begin
            $display("FAILED test %0d: sync_clkvld delay = 0x%0h, expected 0x%0h..0x%0h",
                     cur_test, cycles, int'(row_t_clkwake) + 2,
                     SYNC_STAGES + int'(row_t_clkwake) + 4);
            row_errs++;
        end
        check_gating();
    endtask

    // Masked wake, nothing may move while the row runs
    task automatic check_quiet_row();
        while (row_busy) begin
            check_bit("pgcb_clkreq", pgcb_clkreq, 1'b0);
            check_bit("sync_clkvld", sync_clkvld, 1'b0);
            @(negedge pgcb_clk);
        end
    endtask

    task automatic finish_test(input string what);
        if (row_errs == 0) begin
            n_pass++;
            $display("test %0d %s: passed", cur_test, what);
        end else begin
            n_fail++;
            $display("test %0d %s: failed with %0d errors", cur_test, what, row_errs);
        end
        err_total += row_errs;
    endtask

    initial begin
        cur_test    = 0;
        row_errs    = 0;
        n_pass      = 0;
        n_fail      = 0;
        err_total   = 0;
        report_done = 1'b0;
        // Outputs quiet during reset and shortly after
        @(negedge pgcb_clk);
        while (!pgcb_rst_b) begin
            check_bit("pgcb_clkreq", pgcb_clkreq, 1'b0);
            check_bit("sync_clkvld", sync_clkvld, 1'b0);
            @(negedge pgcb_clk);
        end
        repeat (2) begin
            check_bit("pgcb_clkreq", pgcb_clkreq, 1'b0);
            check_bit("sync_clkvld", sync_clkvld, 1'b0);
            @(negedge pgcb_clk);
        end
        finish_test("(reset)");
        while (!tests_done) begin
            if (row_busy) begin
                cur_test++;
                row_errs = 0;
                if (row_wake_exp) begin
                    check_wake_row();
                end else begin
                    check_quiet_row();
                end
                finish_test($sformatf("(%s wake, pok %0d%s)", row_acc ? "acc" : "pmc",
                                      row_pok, row_cancel ? ", gate cancel" : ""));
                while (row_busy) @(negedge pgcb_clk);
            end else begin
                @(negedge pgcb_clk);
            end
        end
        $display("checker: %0d tests, %0d passed, %0d failed, %0d errors",
                 n_pass + n_fail, n_pass, n_fail, err_total);
        report_done = 1'b1;
    end

endmodule

/* test/pcgu_tb.sv */
`timescale 1ns/10ps

module pcgu_tb;

    localparam int CLK_HALF_NS  = 2;
    localparam int RESET_CYCLES = 2;
    localparam int SYNC_STAGES  = 2;
    localparam int NUM_ROWS     = 8;
    // Event budget per row plus both hysteresis timers at full range
    localparam int WATCHDOG_CYCLES = NUM_ROWS * (64 + 2 * 15) + RESET_CYCLES + 8;

    typedef struct packed {
        logic                       pok;
        logic                       acc;
        logic [pcgu_pkg::TMR_W-1:0] t_wake;
        logic [pcgu_pkg::TMR_W-1:0] t_gate;
        logic                       cancel;
        logic                       wake_exp;
    } row_t;

    // pok, acc wake (else pmc), t_clkwake, t_clkgate, gate cancel, wake expected
    // pok is held through the gating and picks the wakes accepted in the next row
    localparam row_t ROWS [NUM_ROWS] = '{
        '{1'b1, 1'b0, 4'd2,  4'd3,  1'b0, 1'b1},
        '{1'b0, 1'b1, 4'd5,  4'd4,  1'b1, 1'b1},
        '{1'b0, 1'b1, 4'd1,  4'd1,  1'b0, 1'b0},
        '{1'b1, 1'b0, 4'd0,  4'd0,  1'b0, 1'b1},
        '{1'b1, 1'b1, 4'd15, 4'd15, 1'b1, 1'b1},
        '{1'b0, 1'b0, 4'd7,  4'd2,  1'b0, 1'b1},
        '{1'b1, 1'b0, 4'd3,  4'd9,  1'b1, 1'b1},
        '{1'b1, 1'b1, 4'd4,  4'd6,  1'b0, 1'b1}
    };

    logic                       pgcb_clk = 1'b0;
    logic                       pgcb_rst_b;
    logic                       pgcb_clkreq;
    logic                       pgcb_clkack;
    logic [pcgu_pkg::TMR_W-1:0] t_clkgate;
    logic [pcgu_pkg::TMR_W-1:0] t_clkwake;
    logic                       sync_gate;
    logic                       async_wake_b;
    logic                       sync_clkvld;
    logic                       pgcb_pok;
    logic                       async_pmc_ip_wake;

    row_t        cur_row;
    logic        row_busy;
    logic        tests_done;
    logic        report_done;
    int          err_total;
    logic [31:0] lfsr_state;

    always #(CLK_HALF_NS) pgcb_clk = ~pgcb_clk;

    pcgu #(
        .DEF_PWRON   (0),
        .SYNC_STAGES (SYNC_STAGES)
    ) uut (
        .pgcb_clk          (pgcb_clk),
        .pgcb_rst_b        (pgcb_rst_b),
        .pgcb_clkreq       (pgcb_clkreq),
        .pgcb_clkack       (pgcb_clkack),
        .t_clkgate         (t_clkgate),
        .t_clkwake         (t_clkwake),
        .sync_gate         (sync_gate),
        .async_wake_b      (async_wake_b),
        .sync_clkvld       (sync_clkvld),
        .pgcb_pok          (pgcb_pok),
        .async_pmc_ip_wake (async_pmc_ip_wake)
    );

    pcgu_checker #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_checker (
        .pgcb_clk          (pgcb_clk),
        .pgcb_rst_b        (pgcb_rst_b),
        .pgcb_clkreq       (pgcb_clkreq),
        .pgcb_clkack       (pgcb_clkack),
        .sync_gate         (sync_gate),
        .async_wake_b      (async_wake_b),
        .async_pmc_ip_wake (async_pmc_ip_wake),
        .sync_clkvld       (sync_clkvld),
        .row_busy          (row_busy),
        .row_pok           (cur_row.pok),
        .row_acc           (cur_row.acc),
        .row_t_clkwake     (cur_row.t_wake),
        .row_t_clkgate     (cur_row.t_gate),
        .row_cancel        (cur_row.cancel),
        .row_wake_exp      (cur_row.wake_exp),
        .tests_done        (tests_done),
        .err_total         (err_total),
        .report_done       (report_done)
    );

    // ----------------------------------------
    // SoC clock ack model
    // ----------------------------------------

    // Galois form, taps of a maximal 32-bit polynomial
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            val        = val * 2 + int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Ack 1 to 8 cycles after the request, drop one cycle after it goes
    initial begin
        int ack_delay;
        lfsr_state  = 32'h113d;
        pgcb_clkack = 1'b0;
        forever begin
            @(negedge pgcb_clk);
            if (pgcb_clkreq && !pgcb_clkack) begin
                take_bits(3, ack_delay);
                repeat (ack_delay + 1) @(posedge pgcb_clk);
                #1;
                pgcb_clkack = 1'b1;
            end else if (!pgcb_clkreq && pgcb_clkack) begin
                @(posedge pgcb_clk);
                #1;
                pgcb_clkack = 1'b0;
            end
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------

    task automatic step_cycles(input int n);
        repeat (n) @(posedge pgcb_clk);
        #1;
    endtask

    task automatic set_wake(input logic acc, input logic on);
        if (acc) begin
            async_wake_b = ~on;
        end else begin
            async_pmc_ip_wake = on;
        end
    endtask

    task automatic run_row(input row_t row);
        step_cycles(1);
        cur_row   = row;
        pgcb_pok  = row.pok;
        t_clkwake = row.t_wake;
        t_clkgate = row.t_gate;
        row_busy  = 1'b1;
        step_cycles(1);
        set_wake(row.acc, 1'b1);
        if (row.wake_exp) begin
            wait (sync_clkvld);
            step_cycles(1);
            set_wake(row.acc, 1'b0);
            step_cycles(2);
            sync_gate = 1'b1;
            // Withdraw the gate while the gate timer still runs
            if (row.cancel) begin
                step_cycles(2);
                sync_gate = 1'b0;
                wait (sync_clkvld);
                step_cycles(2);
                sync_gate = 1'b1;
            end
            wait (!pgcb_clkreq);
            wait (!pgcb_clkack);
            // Let the ack fall through the synchronizer
            step_cycles(SYNC_STAGES + 4);
            sync_gate = 1'b0;
        end else begin
            step_cycles(32);
            set_wake(row.acc, 1'b0);
        end
        step_cycles(2);
        row_busy = 1'b0;
    endtask

    initial begin
        pgcb_rst_b        = 1'b0;
        t_clkgate         = '0;
        t_clkwake         = '0;
        sync_gate         = 1'b0;
        async_wake_b      = 1'b1;
        pgcb_pok          = 1'b0;
        async_pmc_ip_wake = 1'b0;
        cur_row           = '0;
        row_busy          = 1'b0;
        tests_done        = 1'b0;
        repeat (RESET_CYCLES) @(posedge pgcb_clk);
        #1;
        pgcb_rst_b = 1'b1;
        step_cycles(4);
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(ROWS[i]);
        end
        tests_done = 1'b1;
        wait (report_done);
        if (err_total == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge pgcb_clk);
        $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("** FAIL **");
        $finish;
    end

endmodule

/* pcgu.f */
rtl/pcgu_pkg.sv
rtl/pcgu_wake_if.sv
rtl/pgcb_doublesync.sv
rtl/pcgu_wake_ctrl.sv
rtl/pcgu_seq.sv
rtl/pcgu.sv
test/pcgu_checker.sv
test/pcgu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the pcgu testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module pcgu_tb -f pcgu.f -o pcgu_sim

./obj_dir/pcgu_sim | tee sim.log

if grep -Fxq "** PASS **" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
